//--- accel_pkg.sv
package accel_pkg;

  ////////////////////////////////////////////////////////////
  // Word widths
  ////////////////////////////////////////////////////////////
  localparam int byte_w      = 8;
  localparam int axis_w      = 16;
  localparam int num_axes    = 3;
  localparam int burst_bytes = 6;
  localparam int acl_w       = 15;
  // Kept slice per axis, sign plus four data bits
  localparam int axis_msb_keep = 11;
  localparam int axis_lsb_keep = 7;
  localparam int axis_keep_w   = axis_msb_keep - axis_lsb_keep + 1;

  ////////////////////////////////////////////////////////////
  // Sensor instructions and registers
  ////////////////////////////////////////////////////////////
  localparam logic [byte_w-1:0] instr_write    = 8'h0A;
  localparam logic [byte_w-1:0] instr_read     = 8'h0B;
  localparam logic [byte_w-1:0] addr_power_ctl = 8'h2D;
  // Measurement mode bits for the power control register
  localparam logic [byte_w-1:0] mode_measure   = 8'h02;
  // X low byte, sensor auto-increments through Z high byte
  localparam logic [byte_w-1:0] addr_xdata_l   = 8'h0E;
  // Frame lengths in bytes
  localparam int write_bytes    = 3;
  localparam int read_hdr_bytes = 2;

  ////////////////////////////////////////////////////////////
  // Timing in iclk cycles, 4 MHz clock
  ////////////////////////////////////////////////////////////
  localparam int sclk_div           = 2;
  localparam int powerup_cycles     = 24000;
  localparam int meas_start_cycles  = 160000;
  localparam int read_period_cycles = 40000;
  // Sized for the longest wait
  localparam int wait_w = $clog2(meas_start_cycles + 1);

  // Sample FIFO, depth must be a power of two
  localparam int fifo_depth = 4;
  localparam int fifo_ptr_w = $clog2(fifo_depth);

  // Sequencer phases
  localparam logic [2:0] ph_powerup   = 3'd0;
  localparam logic [2:0] ph_write     = 3'd1;
  localparam logic [2:0] ph_meas_wait = 3'd2;
  localparam logic [2:0] ph_read      = 3'd3;
  localparam logic [2:0] ph_period    = 3'd4;

  // Raw burst, byte 0 is X low byte in the lowest bits
  typedef union packed {
    logic [burst_bytes-1:0][byte_w-1:0] bytes;
    logic [num_axes-1:0][axis_w-1:0]    axes;
  } accel_sample_u;

endpackage

//--- accel_sequencer.sv
`timescale 1ns/1ps

module accel_sequencer import accel_pkg::*; (
  input  logic              iclk,
  input  logic              rst,
  output logic              byte_valid,
  output logic [byte_w-1:0] tx_byte,
  input  logic              byte_ready,
  input  logic [byte_w-1:0] rx_byte,
  input  logic              rx_valid,
  output logic              cs,
  output logic              in_valid,
  output accel_sample_u     in_sample,
  input  logic              in_ready
);

  logic [2:0]        phase;
  logic [wait_w-1:0] wait_cnt;
  logic [2:0]        byte_idx;
  logic              in_burst;
  logic              last_byte;
  logic              start_read;
  logic              data_byte;

  assign in_burst = (phase == ph_write) || (phase == ph_read);
  // Write frame is three bytes, read frame is header plus six data bytes
  assign last_byte = (phase == ph_write) ?
                     (byte_idx == 3'(write_bytes - 1)) :
                     (byte_idx == 3'(read_hdr_bytes + burst_bytes - 1));
  // Only start a read with a free FIFO slot and no sample pending
  assign start_read = (wait_cnt == '0) && in_ready && !in_valid;
  assign data_byte  = (phase == ph_read) && rx_valid &&
                      (byte_idx >= 3'(read_hdr_bytes));

  ////////////////////////////////////////////////////////////
  // Next byte to send
  ////////////////////////////////////////////////////////////
  always_comb begin
    // Dummy byte while clocking in read data
    tx_byte = '0;
    if (phase == ph_write) begin
      case (byte_idx)
        3'd0:    tx_byte = instr_write;
        3'd1:    tx_byte = addr_power_ctl;
        default: tx_byte = mode_measure;
      endcase
    end else if (byte_idx == 3'd0) begin
      tx_byte = instr_read;
    end else if (byte_idx == 3'd1) begin
      tx_byte = addr_xdata_l;
    end
  end

  ////////////////////////////////////////////////////////////
  // Phase FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge iclk) begin
    if (rst) begin
      phase      <= ph_powerup;
      wait_cnt   <= wait_w'(powerup_cycles - 1);
      byte_idx   <= '0;
      byte_valid <= 1'b0;
      cs         <= 1'b1;
      in_valid   <= 1'b0;
    end else begin
      // Shared wait counter, runs down and holds at zero
      if (wait_cnt != '0) begin
        wait_cnt <= wait_cnt - 1'b1;
      end
      // One byte request at a time, next one after rx_valid
      if (in_burst) begin
        if (byte_valid && byte_ready) begin
          byte_valid <= 1'b0;
        end else if (!byte_valid && byte_ready && !rx_valid) begin
          byte_valid <= 1'b1;
        end
      end
      if (in_valid && in_ready) begin
        in_valid <= 1'b0;
      end
      case (phase)
        ph_powerup: begin
          if (wait_cnt == '0) begin
            phase    <= ph_write;
            cs       <= 1'b0;
            byte_idx <= '0;
          end
        end
        ph_write, ph_read: begin
          if (rx_valid) begin
            byte_idx <= byte_idx + 1'b1;
            if (last_byte) begin
              cs <= 1'b1;
              if (phase == ph_write) begin
                phase    <= ph_meas_wait;
                wait_cnt <= wait_w'(meas_start_cycles - 1);
              end else begin
                // Sample complete, offer it to the FIFO
                phase    <= ph_period;
                in_valid <= 1'b1;
              end
            end
          end
        end
        ph_meas_wait, ph_period: begin
          if (start_read) begin
            // Period counts from this cs fall
            phase    <= ph_read;
            cs       <= 1'b0;
            byte_idx <= '0;
            wait_cnt <= wait_w'(read_period_cycles - 1);
          end
        end
        default: begin
          phase <= ph_powerup;
        end
      endcase
    end
  end

  // Data bytes land in arrival order
  always_ff @(posedge iclk) begin
    if (data_byte) begin
      in_sample.bytes[byte_idx - 3'(read_hdr_bytes)] <= rx_byte;
    end
  end

endmodule

//--- accel_spi_assertions.sv
`timescale 1ns/1ps

module accel_spi_assertions import accel_pkg::*; (
  input logic             iclk,
  input logic             rst,
  input logic             cs,
  input logic             sclk,
  input logic             mosi,
  input logic             acl_valid,
  input logic [acl_w-1:0] acl_data,
  input logic             acl_ready
);

  // Count of failed properties so far
  int fail_cnt = 0;

  ////////////////////////////////////////////////////////////
  // SPI pins
  ////////////////////////////////////////////////////////////
  // SCLK idles low outside a frame
  sclk_idle_low: assert property (@(posedge iclk) disable iff (rst) cs |-> !sclk)
    else begin
      $error("sclk high while cs is high");
      fail_cnt++;
    end

  // Mode 0, data only moves while sclk is low
  mosi_stable: assert property (@(posedge iclk) disable iff (rst) sclk |-> $stable(mosi))
    else begin
      $error("mosi changed while sclk was high");
      fail_cnt++;
    end

  // Output word held under back-pressure
  acl_hold: assert property (@(posedge iclk) disable iff (rst)
                             acl_valid && !acl_ready |=> acl_valid && $stable(acl_data))
    else begin
      $error("acl_valid or acl_data moved while acl_ready was low");
      fail_cnt++;
    end

endmodule

bind accel_spi_top accel_spi_assertions i_assertions (
  .iclk      (iclk),
  .rst       (rst),
  .cs        (cs),
  .sclk      (sclk),
  .mosi      (mosi),
  .acl_valid (acl_valid),
  .acl_data  (acl_data),
  .acl_ready (acl_ready)
);

//--- accel_spi_top.sv
`timescale 1ns/1ps

module accel_spi_top import accel_pkg::*; (
  input  logic             iclk,
  input  logic             rst,
  input  logic             miso,
  output logic             sclk,
  output logic             mosi,
  output logic             cs,
  output logic             acl_valid,
  output logic [acl_w-1:0] acl_data,
  input  logic             acl_ready
);

  // Byte request path
  logic              byte_valid;
  logic              byte_ready;
  logic [byte_w-1:0] tx_byte;
  logic [byte_w-1:0] rx_byte;
  logic              rx_valid;
  // Sample push into the FIFO
  logic              in_valid;
  logic              in_ready;
  accel_sample_u     in_sample;
  // FIFO head toward the reducer
  logic              out_valid;
  logic              out_ready;
  accel_sample_u     out_sample;

  ////////////////////////////////////////////////////////////
  // Producer and SPI engine
  ////////////////////////////////////////////////////////////
  accel_sequencer i_sequencer (
    .iclk       (iclk),
    .rst        (rst),
    .byte_valid (byte_valid),
    .tx_byte    (tx_byte),
    .byte_ready (byte_ready),
    .rx_byte    (rx_byte),
    .rx_valid   (rx_valid),
    .cs         (cs),
    .in_valid   (in_valid),
    .in_sample  (in_sample),
    .in_ready   (in_ready)
  );

  spi_byte_shifter i_shifter (
    .iclk       (iclk),
    .rst        (rst),
    .byte_valid (byte_valid),
    .tx_byte    (tx_byte),
    .byte_ready (byte_ready),
    .rx_byte    (rx_byte),
    .rx_valid   (rx_valid),
    .sclk       (sclk),
    .mosi       (mosi),
    .miso       (miso)
  );

  ////////////////////////////////////////////////////////////
  // Buffer and consumer
  ////////////////////////////////////////////////////////////
  sample_fifo i_fifo (
    .iclk       (iclk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_sample  (in_sample),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_sample (out_sample),
    .out_ready  (out_ready)
  );

  acl_reducer i_reducer (
    .iclk       (iclk),
    .rst        (rst),
    .out_valid  (out_valid),
    .out_sample (out_sample),
    .out_ready  (out_ready),
    .acl_valid  (acl_valid),
    .acl_data   (acl_data),
    .acl_ready  (acl_ready)
  );

endmodule

//--- acl_reducer.sv
`timescale 1ns/1ps

module acl_reducer import accel_pkg::*; (
  input  logic             iclk,
  input  logic             rst,
  input  logic             out_valid,
  input  accel_sample_u    out_sample,
  output logic             out_ready,
  output logic             acl_valid,
  output logic [acl_w-1:0] acl_data,
  input  logic             acl_ready
);

  logic [acl_w-1:0] reduced;
  logic             load;

  // Take a new sample when empty or when the held word leaves
  assign out_ready = !acl_valid || acl_ready;
  assign load      = out_valid && out_ready;

  // X in the top bits, then Y, then Z
  always_comb begin
    for (int i = 0; i < num_axes; i++) begin
      reduced[acl_w - 1 - i * axis_keep_w -: axis_keep_w] =
        out_sample.axes[i][axis_msb_keep:axis_lsb_keep];
    end
  end

  always_ff @(posedge iclk) begin
    if (rst) begin
      acl_valid <= 1'b0;
    end else if (load) begin
      acl_valid <= 1'b1;
    end else if (acl_ready) begin
      acl_valid <= 1'b0;
    end
  end

  // Word held while the consumer stalls
  always_ff @(posedge iclk) begin
    if (load) begin
      acl_data <= reduced;
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the accelerometer SPI testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_accel_spi -o tb_accel_spi
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_accel_spi +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" "$log"; then
  exit 1
fi
exit 0

//--- sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo import accel_pkg::*; (
  input  logic          iclk,
  input  logic          rst,
  input  logic          in_valid,
  input  accel_sample_u in_sample,
  output logic          in_ready,
  output logic          out_valid,
  output accel_sample_u out_sample,
  input  logic          out_ready
);

  accel_sample_u         mem [fifo_depth];
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [fifo_ptr_w:0]   count;
  logic                  full;
  logic                  push;
  logic                  pop;

  assign full      = (count == (fifo_ptr_w + 1)'(fifo_depth));
  assign out_valid = (count != '0);
  // When full, a pop in the same cycle frees the slot
  assign in_ready  = !full || out_ready;
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;
  // Head entry shows directly on the output
  assign out_sample = mem[rd_ptr];

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge iclk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge iclk) begin
    if (push) begin
      mem[wr_ptr] <= in_sample;
    end
  end

endmodule

//--- sim.f
accel_pkg.sv
spi_byte_shifter.sv
accel_sequencer.sv
sample_fifo.sv
acl_reducer.sv
accel_spi_top.sv
accel_spi_assertions.sv
tb_accel_spi.sv

//--- spi_byte_shifter.sv
`timescale 1ns/1ps

module spi_byte_shifter import accel_pkg::*; (
  input  logic              iclk,
  input  logic              rst,
  input  logic              byte_valid,
  input  logic [byte_w-1:0] tx_byte,
  output logic              byte_ready,
  output logic [byte_w-1:0] rx_byte,
  output logic              rx_valid,
  output logic              sclk,
  output logic              mosi,
  input  logic              miso
);

  logic              busy;
  logic [3:0]        div_cnt;
  logic [2:0]        bit_cnt;
  logic [byte_w-1:0] tx_shift;
  logic [byte_w-1:0] rx_shift;
  logic              accept;
  logic              half_done;
  logic              rise_edge;
  logic              fall_edge;
  logic              last_bit;

  // Idle means ready for the next byte
  assign byte_ready = ~busy;
  assign accept     = byte_valid && !busy;
  // End of one SCLK half period
  assign half_done  = (div_cnt == 4'(sclk_div - 1));
  assign rise_edge  = busy && half_done && !sclk;
  assign fall_edge  = busy && half_done && sclk;
  assign last_bit   = (bit_cnt == 3'(byte_w - 1));

  ////////////////////////////////////////////////////////////
  // SCLK divider and bit counter
  ////////////////////////////////////////////////////////////
  always_ff @(posedge iclk) begin
    if (rst) begin
      busy     <= 1'b0;
      div_cnt  <= '0;
      bit_cnt  <= '0;
      sclk     <= 1'b0;
      mosi     <= 1'b0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (accept) begin
        // First bit sits on mosi before the first rise of mode 0
        busy    <= 1'b1;
        div_cnt <= '0;
        bit_cnt <= '0;
        mosi    <= tx_byte[byte_w-1];
      end else if (busy && half_done) begin
        div_cnt <= '0;
        sclk    <= ~sclk;
        if (sclk) begin
          // Next bit goes out on the falling edge while sclk is low
          // Zero fill of the shifter leaves mosi low after the last bit
          bit_cnt <= bit_cnt + 1'b1;
          mosi    <= tx_shift[byte_w-1];
          if (last_bit) begin
            busy     <= 1'b0;
            rx_valid <= 1'b1;
          end
        end
      end else if (busy) begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // Data shift registers
  always_ff @(posedge iclk) begin
    if (accept) begin
      tx_shift <= {tx_byte[byte_w-2:0], 1'b0};
    end else if (fall_edge) begin
      tx_shift <= {tx_shift[byte_w-2:0], 1'b0};
    end
    // Sample miso together with the rising sclk
    if (rise_edge) begin
      rx_shift <= {rx_shift[byte_w-2:0], miso};
    end
  end

  assign rx_byte = rx_shift;

endmodule

//--- tb_accel_spi.sv
`timescale 1ns/1ps

module tb_accel_spi import accel_pkg::*; ();

  localparam int num_samples = 8;
  localparam int frame_len   = read_hdr_bytes + burst_bytes;

  logic             iclk;
  logic             rst = 1'b1;
  logic             miso = 1'b0;
  logic             acl_ready = 1'b0;
  logic             sclk;
  logic             mosi;
  logic             cs;
  logic             acl_valid;
  logic [acl_w-1:0] acl_data;

  integer seed = 11;
  int     cyc = 0;
  int     checks = 0;
  int     err_cnt [1:6] = '{default: 0};
  int     got = 0;
  int     stall_end = 0;
  // Sensor model state, one cs-low frame at a time
  logic                          prev_cs = 1'b1;
  logic                          prev_sclk = 1'b0;
  int                            bit_cnt = 0;
  int                            byte_cnt = 0;
  logic [byte_w-1:0]             sh_in = '0;
  logic [byte_w-1:0]             resp = '0;
  logic [byte_w-1:0]             frame_bytes [frame_len];
  logic [burst_bytes*byte_w-1:0] raw = '0;
  int                            frame_num = 0;
  int                            frame_start = 0;
  int                            last_start = 0;
  // Expected output words in frame order
  logic [acl_w-1:0]              exp_q [$];

  accel_spi_top i_dut (
    .iclk      (iclk),
    .rst       (rst),
    .miso      (miso),
    .sclk      (sclk),
    .mosi      (mosi),
    .cs        (cs),
    .acl_valid (acl_valid),
    .acl_data  (acl_data),
    .acl_ready (acl_ready)
  );

  initial begin
    iclk = 1'b0;
    forever #4 iclk = ~iclk;
  end

  // Axes are LSB first byte pairs, keep bits 11..7, X ends up on top
  function automatic logic [acl_w-1:0] expected_word(input logic [burst_bytes*byte_w-1:0] d);
    logic [acl_w-1:0]  w;
    logic [axis_w-1:0] ax;
    w = '0;
    for (int i = 0; i < num_axes; i++) begin
      ax = d[axis_w*i +: axis_w];
      w  = {w[acl_w-axis_keep_w-1:0], ax[axis_msb_keep:axis_lsb_keep]};
    end
    return w;
  endfunction

  task automatic check_value(input int beh, input string name, input int val, input int exp);
    checks++;
    assert (val == exp) else begin
      $display("error %0t %s got 0x%0h expected 0x%0h", $time, name, val, exp);
      err_cnt[beh]++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Frame checks at cs rise
  ////////////////////////////////////////////////////////////
  task automatic close_frame();
    if (frame_num == 0) begin
      check_value(2, "write frame length", byte_cnt, write_bytes);
      check_value(2, "mosi instr", int'(frame_bytes[0]), int'(instr_write));
      check_value(2, "mosi addr", int'(frame_bytes[1]), int'(addr_power_ctl));
      check_value(2, "mosi data", int'(frame_bytes[2]), int'(mode_measure));
      $display("behavior 2 configuration frame: %0d errors", err_cnt[2]);
    end else begin
      check_value(3, "read frame length", byte_cnt, frame_len);
      check_value(3, "mosi instr", int'(frame_bytes[0]), int'(instr_read));
      check_value(3, "mosi addr", int'(frame_bytes[1]), int'(addr_xdata_l));
      if (frame_num > 1) begin
        checks++;
        assert (frame_start - last_start >= read_period_cycles) else begin
          $display("read frame started only %0d cycles after the one before",
                   frame_start - last_start);
          err_cnt[6]++;
        end
      end
      last_start = frame_start;
      exp_q.push_back(expected_word(raw));
    end
    frame_num++;
  endtask

  ////////////////////////////////////////////////////////////
  // Sensor model and output consumer
  ////////////////////////////////////////////////////////////
  always @(posedge iclk) begin
    #1;
    cyc++;
    // Bus stays quiet until the configuration frame
    if (frame_num == 0 && prev_cs && cs) begin
      check_value(1, "sclk", int'(sclk), 0);
      check_value(1, "acl_valid", int'(acl_valid), 0);
    end
    if (prev_cs && !cs) begin
      bit_cnt     = 0;
      byte_cnt    = 0;
      resp        = '0;
      frame_start = cyc;
      if (frame_num == 0) begin
        checks++;
        assert (frame_start >= powerup_cycles) else begin
          $display("configuration frame opened after only %0d cycles", frame_start);
          err_cnt[1]++;
        end
        $display("behavior 1 idle after reset: %0d errors", err_cnt[1]);
      end
    end
    // Mode 0, mosi is taken on the sclk rise
    if (!cs && !prev_sclk && sclk) begin
      sh_in = {sh_in[byte_w-2:0], mosi};
      bit_cnt++;
      if (bit_cnt == byte_w) begin
        if (byte_cnt < frame_len) begin
          frame_bytes[byte_cnt] = sh_in;
        end
        if (byte_cnt >= read_hdr_bytes && byte_cnt < frame_len) begin
          raw[byte_w*(byte_cnt-read_hdr_bytes) +: byte_w] = resp;
        end
        byte_cnt++;
        bit_cnt = 0;
        // Random data only after a read header
        if (byte_cnt >= read_hdr_bytes && byte_cnt < frame_len && frame_bytes[0] == instr_read)
          resp = 8'($random(seed));
        else
          resp = '0;
      end
    end
    // miso only moves while sclk is low
    if (!sclk) begin
      miso = resp[byte_w-1-bit_cnt];
    end
    if (!prev_cs && cs) begin
      close_frame();
    end
    prev_cs   = cs;
    prev_sclk = sclk;
    // Random ready, plus one long stall that fills the FIFO
    if (cyc < stall_end) begin
      acl_ready = 1'b0;
    end else begin
      acl_ready = 1'($random(seed));
    end
    if (acl_valid && acl_ready) begin
      checks++;
      assert (exp_q.size() > 0) else begin
        $display("output word 0x%0h accepted with no read frame behind it", acl_data);
        err_cnt[5]++;
      end
      if (exp_q.size() > 0) begin
        check_value((got < 2) ? 4 : 5, "acl_data", int'(acl_data), int'(exp_q.pop_front()));
      end
      got++;
      if (got == 2) begin
        stall_end = cyc + 6 * read_period_cycles;
      end
    end
  end

  initial begin
    int wait_cnt;
    int total;
    repeat (2) @(posedge iclk);
    #1;
    rst = 1'b0;
    wait_cnt = 0;
    while (frame_num < 1 && wait_cnt < powerup_cycles + 1000) begin
      @(posedge iclk);
      wait_cnt++;
    end
    if (frame_num < 1) begin
      $display("timeout, the configuration frame never closed");
      $display("TEST FAIL");
      $finish;
    end
    wait_cnt = 0;
    while (got < num_samples && wait_cnt < meas_start_cycles + 20 * read_period_cycles) begin
      @(posedge iclk);
      wait_cnt++;
    end
    if (got < num_samples) begin
      $display("timeout with only %0d of %0d output words taken", got, num_samples);
      $display("TEST FAIL");
      $finish;
    end
    $display("behavior 3 read frame format: %0d frames, %0d errors", frame_num - 1, err_cnt[3]);
    $display("behavior 4 data before back-pressure: %0d errors", err_cnt[4]);
    $display("behavior 5 data through back-pressure: %0d errors", err_cnt[5]);
    $display("behavior 6 read period spacing: %0d errors", err_cnt[6]);
    total = i_dut.i_assertions.fail_cnt;
    for (int i = 1; i <= 6; i++) begin
      total += err_cnt[i];
    end
    $display("checks %0d, errors %0d, assertion failures %0d", checks, total,
             i_dut.i_assertions.fail_cnt);
    if (total == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
